// File: ooo_execute.f
+incdir+hw
+incdir+test
hw/ooo_execute_pkg.sv
hw/int_alu.sv
hw/branch_resolver.sv
hw/mul_pipeline.sv
hw/commit_slot.sv
hw/execute_control.sv
hw/ooo_execute.sv
test/ooo_execute_tb.sv

// File: Bender.yml
package:
  name: ooo_execute

sources:
  - include_dirs:
      - hw
    files:
      - hw/ooo_execute_pkg.sv
      - hw/int_alu.sv
      - hw/branch_resolver.sv
      - hw/mul_pipeline.sv
      - hw/commit_slot.sv
      - hw/execute_control.sv
      - hw/ooo_execute.sv

  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/ooo_execute_tb.sv

// File: test/ooo_execute_vectors.svh
/*
 * Execute stage test vectors. Operation, operands and expected results.
 */
`ifndef OOO_EXECUTE_VECTORS_SVH
`define OOO_EXECUTE_VECTORS_SVH

// exp_data is the written value, or the resolved address for branches
// exp_redirect only matters for jumps
typedef struct {
  op_class_t cls;
  func_t     fn;
  word_t     a;
  word_t     b;
  word_t     imm;
  word_t     pc;
  logic      pred;
  word_t     exp_data;
  logic      exp_taken;
  word_t     exp_redirect;
} vec_t;

localparam int NUM_VECTORS = 23;

// cls fn a b imm pc pred exp_data exp_taken exp_redirect
vec_t vectors [NUM_VECTORS] = '{
  '{OP_ALU, F_ADD,  32'd5, 32'd7, 32'd0, 32'd0, 1'b0, 32'd12, 1'b0, 32'd0},
  '{OP_ALU, F_SUB,  32'd5, 32'd7, 32'd0, 32'd0, 1'b0, 32'hffff_fffe, 1'b0, 32'd0},
  '{OP_ALU, F_AND,  32'hf0f0, 32'hff00, 32'd0, 32'd0, 1'b0, 32'hf000, 1'b0, 32'd0},
  '{OP_ALU, F_OR,   32'hf0f0, 32'hff00, 32'd0, 32'd0, 1'b0, 32'hfff0, 1'b0, 32'd0},
  '{OP_ALU, F_XOR,  32'hf0f0, 32'hff00, 32'd0, 32'd0, 1'b0, 32'h0ff0, 1'b0, 32'd0},
  '{OP_ALU, F_SLL,  32'd1, 32'd4, 32'd0, 32'd0, 1'b0, 32'h10, 1'b0, 32'd0},
  '{OP_ALU, F_SRL,  32'h8000_0000, 32'd4, 32'd0, 32'd0, 1'b0, 32'h0800_0000, 1'b0, 32'd0},
  '{OP_ALU, F_SRA,  32'h8000_0000, 32'd4, 32'd0, 32'd0, 1'b0, 32'hf800_0000, 1'b0, 32'd0},
  '{OP_ALU, F_SLT,  32'hffff_ffff, 32'd5, 32'd0, 32'd0, 1'b0, 32'd1, 1'b0, 32'd0},
  '{OP_ALU, F_SLTU, 32'hffff_ffff, 32'd5, 32'd0, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0},
  '{OP_JUMP, F_JAL,  32'd0, 32'd0, 32'h20, 32'h100, 1'b0, 32'h104, 1'b0, 32'h120},
  '{OP_JUMP, F_JALR, 32'h201, 32'd0, 32'h8, 32'h300, 1'b0, 32'h304, 1'b0, 32'h208},
  '{OP_BRANCH, F_BEQ,  32'd3, 32'd3, 32'h40, 32'h1000, 1'b0, 32'h1040, 1'b1, 32'd0},
  '{OP_BRANCH, F_BNE,  32'd3, 32'd3, 32'h40, 32'h1000, 1'b1, 32'h1004, 1'b0, 32'd0},
  '{OP_BRANCH, F_BLT,  32'hffff_ffff, 32'd1, 32'h40, 32'h1000, 1'b1, 32'h1040, 1'b1, 32'd0},
  '{OP_BRANCH, F_BGE,  32'hffff_ffff, 32'd1, 32'h40, 32'h1000, 1'b0, 32'h1004, 1'b0, 32'd0},
  '{OP_BRANCH, F_BLTU, 32'hffff_ffff, 32'd1, 32'h40, 32'h1000, 1'b0, 32'h1004, 1'b0, 32'd0},
  '{OP_BRANCH, F_BGEU, 32'hffff_ffff, 32'd1, 32'h40, 32'h1000, 1'b0, 32'h1040, 1'b1, 32'd0},
  '{OP_MUL, F_MUL,    32'd7, 32'hffff_fffd, 32'd0, 32'd0, 1'b0, 32'hffff_ffeb, 1'b0, 32'd0},
  '{OP_MUL, F_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'd0, 32'd0, 1'b0, 32'd0, 1'b0, 32'd0},
  '{OP_MUL, F_MULH,   32'h8000_0000, 32'h8000_0000, 32'd0, 32'd0, 1'b0, 32'h4000_0000, 1'b0, 32'd0},
  '{OP_MUL, F_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'd0, 32'd0, 1'b0, 32'hffff_ffff, 1'b0, 32'd0},
  '{OP_MUL, F_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'd0, 32'd0, 1'b0, 32'hffff_fffe, 1'b0, 32'd0}
};

`endif

// File: test/ooo_execute_tb.sv
/*
 * Execute stage testbench. Table of operations, random ALU ops,
 * back-to-back multiplies, commit stall and flush.
 */
`timescale 1ns/1ps

module ooo_execute_tb import ooo_execute_pkg::*; ();

  `include "ooo_execute_vectors.svh"

  logic CLK, nRST, issue_valid, prediction, flush, stall_commit;
  op_class_t op_class;
  func_t func;
  word_t port_a, port_b, imm, pc;
  reg_idx_t rd;
  cb_idx_t cb_index;
  logic issue_ready, au_done, mu_done, br_done, br_taken, br_prediction, mispredict;
  reg_idx_t au_rd, mu_rd;
  cb_idx_t au_index, mu_index, br_index;
  word_t au_wdata, mu_wdata, br_resolved_addr, redirect_addr;

  int errors = 0;
  int tests = 0;
  int failed = 0;
  int err_before;
  int cyc;
  vec_t v;

  ooo_execute ooo_execute_i (.*);

  always #20 CLK = ~CLK;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors != err_before) begin
      failed++;
      $display("test %0d %s: FAIL", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
    err_before = errors;
  endtask

  // call right after a rising edge
  task automatic drive_op(input vec_t o, input logic p, input reg_idx_t r, input cb_idx_t i);
    issue_valid <= 1'b1;
    op_class <= o.cls;
    func <= o.fn;
    port_a <= o.a;
    port_b <= o.b;
    imm <= o.imm;
    pc <= o.pc;
    prediction <= p;
    rd <= r;
    cb_index <= i;
  endtask

  // unit 0 au, 1 br, 2 mu; returns cycles counted from the accept edge
  task automatic wait_done(input int unit, output int cycles);
    logic seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < 10) begin
      @(negedge CLK);
      cycles++;
      seen = (unit == 0) ? au_done : (unit == 1) ? br_done : mu_done;
      if (!seen) @(posedge CLK);
    end
    if (!seen) begin
      $display("timeout: unit %0d never raised its done flag", unit);
      errors++;
    end
  endtask

  function automatic word_t alu_model(input func_t f, input word_t a, input word_t b);
    case (f)
      F_ADD:   return a + b;
      F_SUB:   return a + ~b + 1;
      F_AND:   return a & b;
      F_OR:    return a | b;
      F_XOR:   return a ^ b;
      F_SLL:   return a << b[4:0];
      F_SRL:   return a >> b[4:0];
      F_SRA:   return word_t'($signed(a) >>> b[4:0]);
      F_SLT:   return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
      default: return word_t'(a < b);
    endcase
  endfunction

  task automatic run_row(input vec_t o, input logic p, input int id);
    logic exp_misp;
    word_t exp_redir;
    int unit;
    exp_misp = (o.cls == OP_JUMP) || (o.cls == OP_BRANCH && p != o.exp_taken);
    exp_redir = (o.cls == OP_JUMP) ? o.exp_redirect : o.exp_data;
    unit = (o.cls == OP_BRANCH) ? 1 : (o.cls == OP_MUL) ? 2 : 0;
    @(posedge CLK);
    drive_op(o, p, reg_idx_t'(id + 1), cb_idx_t'(id));
    // redirect is combinational in the accept cycle
    @(negedge CLK);
    check_word("mispredict", mispredict, exp_misp);
    if (exp_misp) check_word("redirect_addr", redirect_addr, exp_redir);
    @(posedge CLK);
    issue_valid <= 1'b0;
    wait_done(unit, cyc);
    check_word("latency", cyc, (unit == 2) ? 4 : 1);
    if (unit == 0) begin
      check_word("au_wdata", au_wdata, o.exp_data);
      check_word("au_rd", au_rd, reg_idx_t'(id + 1));
      check_word("au_index", au_index, cb_idx_t'(id));
    end else if (unit == 1) begin
      check_word("br_resolved_addr", br_resolved_addr, o.exp_data);
      check_word("br_taken", br_taken, o.exp_taken);
      check_word("br_prediction", br_prediction, p);
      check_word("br_index", br_index, cb_idx_t'(id));
    end else begin
      check_word("mu_wdata", mu_wdata, o.exp_data);
      check_word("mu_rd", mu_rd, reg_idx_t'(id + 1));
      check_word("mu_index", mu_index, cb_idx_t'(id));
    end
  endtask

  initial begin
    int seed;
    seed = 32'hfb11_9e8f;
    void'($urandom(seed));
    CLK = 1'b0;
    nRST <= 1'b0;
    issue_valid <= 1'b0;
    op_class <= OP_ALU;
    func <= F_ADD;
    port_a <= '0;
    port_b <= '0;
    imm <= '0;
    pc <= '0;
    rd <= '0;
    cb_index <= '0;
    prediction <= 1'b0;
    flush <= 1'b0;
    stall_commit <= 1'b0;
    err_before = 0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);

    // table rows; branches run with both predictions
    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_row(vectors[i], vectors[i].pred, i);
      if (vectors[i].cls == OP_BRANCH) run_row(vectors[i], !vectors[i].pred, i);
      finish_test($sformatf("vector %0d", i));
    end

    // random alu operands
    for (int i = 0; i < 12; i++) begin
      v = vectors[0];
      v.fn = func_t'($urandom % 10);
      v.a = $urandom;
      v.b = $urandom;
      v.exp_data = alu_model(v.fn, v.a, v.b);
      run_row(v, 1'b0, i);
      finish_test($sformatf("random alu %0d", i));
    end

    // three multiplies in flight, completing in order
    v = vectors[18];
    for (int i = 0; i < 3; i++) begin
      @(posedge CLK);
      v.a = 32'd100 + i;
      drive_op(v, 1'b0, reg_idx_t'(20 + i), cb_idx_t'(10 + i));
    end
    @(posedge CLK);
    issue_valid <= 1'b0;
    wait_done(2, cyc);
    // first op was accepted two edges before the wait began
    check_word("latency", cyc, 2);
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        @(posedge CLK);
        @(negedge CLK);
      end
      check_word("mu_done", mu_done, 1'b1);
      check_word("mu_rd", mu_rd, reg_idx_t'(20 + i));
      check_word("mu_index", mu_index, cb_idx_t'(10 + i));
      check_word("mu_wdata", mu_wdata, (32'd100 + i) * 32'hffff_fffd);
    end
    finish_test("mul back to back");

    // pending alu result held through a stall
    @(posedge CLK);
    drive_op(vectors[0], 1'b0, 5'd7, 4'd3);
    @(posedge CLK);
    issue_valid <= 1'b0;
    stall_commit <= 1'b1;
    @(negedge CLK);
    check_word("au_done", au_done, 1'b1);
    check_word("au_wdata", au_wdata, vectors[0].exp_data);
    for (int i = 0; i < 3; i++) begin
      @(posedge CLK);
      @(negedge CLK);
      check_word("issue_ready", issue_ready, 1'b0);
      check_word("au_done", au_done, 1'b1);
      check_word("au_wdata", au_wdata, vectors[0].exp_data);
    end
    @(posedge CLK);
    stall_commit <= 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    check_word("au_done", au_done, 1'b0);
    finish_test("stall alu");

    // multiply stalled for three edges mid-pipeline
    @(posedge CLK);
    drive_op(vectors[18], 1'b0, 5'd9, 4'd4);
    @(posedge CLK);
    issue_valid <= 1'b0;
    @(posedge CLK);
    stall_commit <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge CLK);
      check_word("issue_ready", issue_ready, 1'b0);
      check_word("mu_done", mu_done, 1'b0);
      @(posedge CLK);
    end
    stall_commit <= 1'b0;
    wait_done(2, cyc);
    check_word("stalled latency", cyc, 3);
    check_word("mu_wdata", mu_wdata, vectors[18].exp_data);
    check_word("mu_rd", mu_rd, 5'd9);
    finish_test("stall mul");

    // flush with two multiplies and an alu op in flight
    @(posedge CLK);
    drive_op(vectors[18], 1'b0, 5'd1, 4'd1);
    @(posedge CLK);
    drive_op(vectors[19], 1'b0, 5'd2, 4'd2);
    @(posedge CLK);
    drive_op(vectors[0], 1'b0, 5'd3, 4'd3);
    @(posedge CLK);
    issue_valid <= 1'b0;
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge CLK);
      if (au_done || mu_done || br_done) begin
        $display("done flag raised %0d cycles after flush", i + 1);
        errors++;
      end
      @(posedge CLK);
    end
    finish_test("flush");

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: hw/ooo_execute.sv
/*
 * Integer execute stage top. Control, ALU, branch resolver,
 * multiplier and the three commit slots.
 */
`timescale 1ns/1ps

module ooo_execute import ooo_execute_pkg::*; (
  input  logic CLK, nRST, issue_valid, prediction, flush, stall_commit,
  input  op_class_t op_class,
  input  func_t func,
  input  word_t port_a, port_b, imm, pc,
  input  reg_idx_t rd,
  input  cb_idx_t cb_index,
  output logic issue_ready, au_done, mu_done, br_done, br_taken, br_prediction,
  output reg_idx_t au_rd, mu_rd,
  output cb_idx_t au_index, mu_index, br_index,
  output word_t au_wdata, mu_wdata, br_resolved_addr,
  output logic mispredict,
  output word_t redirect_addr
);

  logic mul_start, mul_advance, mul_clear, au_capture, br_capture;
  logic slot_hold, slot_clear, taken, mul_valid;
  word_t alu_result, resolved_addr;
  wb_payload_t mul_payload, au_payload, mu_payload;
  br_payload_t br_payload;

  execute_control control_i (.*);

  int_alu alu_i (.func, .port_a, .port_b, .pc, .op_class, .result(alu_result));

  branch_resolver branch_i (
    .op_class, .func, .port_a, .port_b, .imm, .pc, .prediction,
    .valid(au_capture | br_capture), .taken, .resolved_addr, .mispredict, .redirect_addr
  );

  mul_pipeline mul_i (
    .CLK, .nRST, .start(mul_start), .advance(mul_advance), .clear(mul_clear), .func,
    .port_a, .port_b, .rd, .cb_index, .out_valid(mul_valid), .out_payload(mul_payload)
  );

  commit_slot #(.payload_t(wb_payload_t)) au_slot_i (
    .CLK, .nRST, .capture(au_capture), .hold(slot_hold), .clear(slot_clear),
    .in_payload('{rd: rd, index: cb_index, data: alu_result}),
    .done(au_done), .out_payload(au_payload)
  );

  commit_slot #(.payload_t(wb_payload_t)) mu_slot_i (
    .CLK, .nRST, .capture(mul_valid), .hold(slot_hold), .clear(slot_clear),
    .in_payload(mul_payload), .done(mu_done), .out_payload(mu_payload)
  );

  commit_slot #(.payload_t(br_payload_t)) br_slot_i (
    .CLK, .nRST, .capture(br_capture), .hold(slot_hold), .clear(slot_clear),
    .in_payload('{index: cb_index, taken: taken, prediction: prediction,
                  resolved_addr: resolved_addr}),
    .done(br_done), .out_payload(br_payload)
  );

  // slot payloads out to the commit stage
  assign au_rd            = au_payload.rd;
  assign au_index         = au_payload.index;
  assign au_wdata         = au_payload.data;
  assign mu_rd            = mu_payload.rd;
  assign mu_index         = mu_payload.index;
  assign mu_wdata         = mu_payload.data;
  assign br_index         = br_payload.index;
  assign br_taken         = br_payload.taken;
  assign br_prediction    = br_payload.prediction;
  assign br_resolved_addr = br_payload.resolved_addr;

endmodule

// File: hw/execute_control.sv
/*
 * Execute control. Accepts issued operations, steers them to a unit
 * and turns flush and commit stall into slot commands.
 */
`timescale 1ns/1ps

module execute_control import ooo_execute_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      issue_valid,
  input  op_class_t op_class,
  input  logic      flush,
  input  logic      stall_commit,
  output logic      issue_ready,
  output logic      mul_start,
  output logic      mul_advance,
  output logic      mul_clear,
  output logic      au_capture,
  output logic      br_capture,
  output logic      slot_hold,
  output logic      slot_clear
);

  logic accept;

  assign issue_ready = !stall_commit;

  // an op arriving alongside a flush is dropped
  assign accept = issue_valid && issue_ready && !flush;

  // jumps share the arithmetic slot for their link value
  assign au_capture = accept && (op_class == OP_ALU || op_class == OP_JUMP);
  assign br_capture = accept && (op_class == OP_BRANCH);
  assign mul_start  = accept && (op_class == OP_MUL);

  assign mul_advance = !stall_commit && !flush;
  assign mul_clear   = flush;

  assign slot_hold  = stall_commit;
  assign slot_clear = flush;

  assert property (@(posedge CLK) disable iff (!nRST) !(au_capture && br_capture));

  assert property (@(posedge CLK) disable iff (!nRST)
    stall_commit |-> !(au_capture || br_capture || mul_start));

endmodule

// File: hw/commit_slot.sv
/*
 * Execute-to-commit slot. Registers one result with a done flag,
 * holds under commit stall and empties on flush.
 */
`timescale 1ns/1ps

module commit_slot import ooo_execute_pkg::*; #(
  parameter type payload_t = wb_payload_t
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     capture,
  input  logic     hold,
  input  logic     clear,
  input  payload_t in_payload,
  output logic     done,
  output payload_t out_payload
);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      done <= 1'b0;
    end else if (clear) begin
      done <= 1'b0;
    end else if (!hold) begin
      done <= capture;
    end
  end

  always_ff @(posedge CLK) begin
    if (clear) begin
      out_payload <= '0;
    end else if (!hold && capture) begin
      out_payload <= in_payload;
    end
  end

  // a done result is either freshly captured or one held over a stall
  assert property (@(posedge CLK) disable iff (!nRST)
    done |-> ($past(hold) ? $past(done) : $past(capture)));

endmodule

// File: hw/mul_pipeline.sv
/*
 * Pipelined RV32M multiplier. Operands, product and half select
 * occupy one stage each; rd and completion index ride along.
 */
`timescale 1ns/1ps
`include "ooo_execute_macros.svh"

module mul_pipeline import ooo_execute_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        start,
  input  logic        advance,
  input  logic        clear,
  input  func_t       func,
  input  word_t       port_a,
  input  word_t       port_b,
  input  reg_idx_t    rd,
  input  cb_idx_t     cb_index,
  output logic        out_valid,
  output wb_payload_t out_payload
);

  localparam int LAST = `MUL_STAGES - 1;

  logic [`MUL_STAGES-1:0]    stage_valid;
  reg_idx_t                  stage_rd    [`MUL_STAGES];
  cb_idx_t                   stage_index [`MUL_STAGES];
  logic                      a_signed;
  logic                      b_signed;
  logic signed [`XLEN:0]     op_a_q;
  logic signed [`XLEN:0]     op_b_q;
  logic                      hi_q0;
  logic                      hi_q1;
  logic signed [2*`XLEN+1:0] product;
  logic [2*`XLEN-1:0]        product_q;
  word_t                     result_q;

  // operand signedness per function
  assign a_signed = (func == F_MULH) || (func == F_MULHSU);
  assign b_signed = (func == F_MULH);

  assign product = op_a_q * op_b_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      stage_valid <= '0;
    end else if (clear) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[LAST-1:0], start};
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      stage_rd[0]    <= rd;
      stage_index[0] <= cb_index;
      for (int i = 1; i < `MUL_STAGES; i++) begin
        stage_rd[i]    <= stage_rd[i-1];
        stage_index[i] <= stage_index[i-1];
      end
      // stage 1 sign-extends to 33 bits so one signed multiply covers all four
      op_a_q    <= {a_signed & port_a[`XLEN-1], port_a};
      op_b_q    <= {b_signed & port_b[`XLEN-1], port_b};
      hi_q0     <= (func != F_MUL);
      product_q <= product[2*`XLEN-1:0];
      hi_q1     <= hi_q0;
      result_q  <= hi_q1 ? product_q[2*`XLEN-1:`XLEN] : product_q[`XLEN-1:0];
    end
  end

  assign out_valid         = stage_valid[LAST];
  assign out_payload.rd    = stage_rd[LAST];
  assign out_payload.index = stage_index[LAST];
  assign out_payload.data  = result_q;

  // flush must win over any pipeline movement
  assert property (@(posedge CLK) disable iff (!nRST) clear |-> !advance);

endmodule

// File: hw/branch_resolver.sv
/*
 * Branch resolution. Evaluates the condition, forms jump targets
 * and raises a redirect when the front end guessed wrong.
 */
`timescale 1ns/1ps

module branch_resolver import ooo_execute_pkg::*; (
  input  op_class_t op_class,
  input  func_t     func,
  input  word_t     port_a,
  input  word_t     port_b,
  input  word_t     imm,
  input  word_t     pc,
  input  logic      prediction,
  input  logic      valid,
  output logic      taken,
  output word_t     resolved_addr,
  output logic      mispredict,
  output word_t     redirect_addr
);

  logic  is_branch;
  logic  is_jump;
  logic  cond;
  word_t branch_target;
  word_t jump_target;
  word_t pc4;

  assign is_branch = (op_class == OP_BRANCH);
  assign is_jump   = (op_class == OP_JUMP);

  always_comb begin
    case (func)
      F_BEQ:   cond = (port_a == port_b);
      F_BNE:   cond = (port_a != port_b);
      F_BLT:   cond = ($signed(port_a) < $signed(port_b));
      F_BGE:   cond = ($signed(port_a) >= $signed(port_b));
      F_BLTU:  cond = (port_a < port_b);
      F_BGEU:  cond = (port_a >= port_b);
      default: cond = 1'b0;
    endcase
  end

  assign pc4           = pc + 32'd4;
  assign branch_target = pc + imm;

  // jalr drops bit 0 of the computed address
  assign jump_target = (func == F_JALR) ? ((port_a + imm) & ~32'd1) : branch_target;

  assign taken         = is_branch & cond;
  assign resolved_addr = taken ? branch_target : pc4;

  // jumps always redirect, branches only on a wrong guess
  assign mispredict    = valid & (is_jump | (is_branch & (prediction != taken)));
  assign redirect_addr = is_jump ? jump_target : resolved_addr;

endmodule

// File: hw/int_alu.sv
/*
 * Integer ALU. Ten RV32I register operations, plus the pc+4
 * link value for jumps.
 */
`timescale 1ns/1ps

module int_alu import ooo_execute_pkg::*; (
  input  func_t     func,
  input  word_t     port_a,
  input  word_t     port_b,
  input  word_t     pc,
  input  op_class_t op_class,
  output word_t     result
);

  word_t    alu_out;
  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (func)
      F_ADD:   alu_out = port_a + port_b;
      F_SUB:   alu_out = port_a - port_b;
      F_AND:   alu_out = port_a & port_b;
      F_OR:    alu_out = port_a | port_b;
      F_XOR:   alu_out = port_a ^ port_b;
      F_SLL:   alu_out = port_a << shamt;
      F_SRL:   alu_out = port_a >> shamt;
      F_SRA:   alu_out = word_t'($signed(port_a) >>> shamt);
      F_SLT:   alu_out = word_t'($signed(port_a) < $signed(port_b));
      F_SLTU:  alu_out = word_t'(port_a < port_b);
      default: alu_out = '0;
    endcase
  end

  // jal and jalr both write the return address
  assign result = (op_class == OP_JUMP) ? pc + 32'd4 : alu_out;

endmodule

// File: hw/ooo_execute_pkg.sv
/*
 * Execute stage package. Operation classes, per-class function codes
 * and the result payloads carried into the commit slots.
 */
`include "ooo_execute_macros.svh"

package ooo_execute_pkg;

  localparam int CB_IDX_W = $clog2(`CB_ENTRIES);

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [CB_IDX_W-1:0]    cb_idx_t;

  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_BRANCH = 2'd1,
    OP_JUMP   = 2'd2,
    OP_MUL    = 2'd3
  } op_class_t;

  typedef logic [3:0] func_t;

  // alu functions
  localparam func_t F_ADD  = 4'h0;
  localparam func_t F_SUB  = 4'h1;
  localparam func_t F_AND  = 4'h2;
  localparam func_t F_OR   = 4'h3;
  localparam func_t F_XOR  = 4'h4;
  localparam func_t F_SLL  = 4'h5;
  localparam func_t F_SRL  = 4'h6;
  localparam func_t F_SRA  = 4'h7;
  localparam func_t F_SLT  = 4'h8;
  localparam func_t F_SLTU = 4'h9;

  // branch conditions, same order as funct3
  localparam func_t F_BEQ  = 4'h0;
  localparam func_t F_BNE  = 4'h1;
  localparam func_t F_BLT  = 4'h4;
  localparam func_t F_BGE  = 4'h5;
  localparam func_t F_BLTU = 4'h6;
  localparam func_t F_BGEU = 4'h7;

  // jumps
  localparam func_t F_JAL  = 4'h0;
  localparam func_t F_JALR = 4'h1;

  // multiplies
  localparam func_t F_MUL    = 4'h0;
  localparam func_t F_MULH   = 4'h1;
  localparam func_t F_MULHSU = 4'h2;
  localparam func_t F_MULHU  = 4'h3;

  // register writeback result, 41 bits
  typedef struct packed {
    reg_idx_t rd;
    cb_idx_t  index;
    word_t    data;
  } wb_payload_t;

  // branch outcome for the predictor update, 38 bits
  typedef struct packed {
    cb_idx_t index;
    logic    taken;
    logic    prediction;
    word_t   resolved_addr;
  } br_payload_t;

endpackage

// File: hw/ooo_execute_macros.svh
/*
 * Execute stage sizing. Data width, register index width,
 * completion buffer depth and multiplier pipeline depth.
 */
`ifndef OOO_EXECUTE_MACROS_SVH
`define OOO_EXECUTE_MACROS_SVH

// data word width
`define XLEN 32

// architectural register index width
`define REG_ADDR_W 5

// completion buffer entries, index width follows from this
`define CB_ENTRIES 16

// multiplier pipeline depth
`define MUL_STAGES 3

`endif
